// ==== axis_interp_top.f ====
+incdir+hdl
hdl/interp_pkg.sv
hdl/axis_zero_pad.sv
hdl/axis_fir_interp.sv
hdl/axis_gain_sat.sv
hdl/axis_interp_top.sv
dv/tb_axis_interp_top.sv

// ==== dv/tb_axis_interp_top.sv ====
/*
  testbench for the complex x4 interpolator
  random frames, gains and back-pressure checked against a reference model
*/
`include "interp_settings.svh"

module tb_axis_interp_top
  import interp_pkg::*;
();

  localparam int     PERIOD    = 40;
  localparam int     DRIVE_DLY = 2;
  localparam int     TIMEOUT   = 200;
  localparam int     PAD       = `INTERP_PAD_SIZE;
  localparam int     TAPS      = `INTERP_TAPS;
  localparam longint COEF_HALF = longint'(1) <<< (`INTERP_COEF_FRAC - 1);
  localparam longint GAIN_HALF = longint'(1) <<< (`INTERP_GAIN_FRAC - 1);

  // triangle taps with the newest sample first
  localparam int COEF [0:TAPS-1] = '{0, 4096, 8192, 12288, 16384, 12288, 8192, 4096};

  logic     clk = 1'b0;
  logic     reset;
  logic     s_axis_tvalid;
  logic     s_axis_tready;
  iq_word_t s_axis_tdata;
  logic     s_axis_tlast;
  gain_t    gain;
  logic     m_axis_tvalid;
  logic     m_axis_tready;
  iq_word_t m_axis_tdata;
  logic     m_axis_tlast;
  logic     sat;

  // model delay line and expected beats
  int       hist_i [0:TAPS-1];
  int       hist_q [0:TAPS-1];
  iq_word_t exp_data [$];
  logic     exp_last [$];
  logic     exp_sat [$];

  logic     bp_en     = 1'b0;
  logic     gaps_en   = 1'b0;
  logic     lat_armed = 1'b0;
  int       first_out = -1;
  int       sat_count = 0;
  int       cycle     = 0;

  axis_interp_top u_axis_interp_top (
    .clk           (clk),
    .reset         (reset),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tlast  (s_axis_tlast),
    .gain          (gain),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tlast  (m_axis_tlast),
    .sat           (sat)
  );

  always #(PERIOD / 2) clk = ~clk;

  always @(posedge clk) cycle <= cycle + 1;

  // sink ready with random stalls when enabled
  initial begin
    m_axis_tready = 1'b1;
    forever begin
      @(posedge clk);
      #DRIVE_DLY;
      m_axis_tready = bp_en ? ($urandom_range(3) != 0) : 1'b1;
    end
  end

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      fail_run($sformatf("Error: %0t: %s is %h, expected %h", $time, what, actual, expected));
    end
  endtask

  //////////////////////////////////////////
  // reference model
  //////////////////////////////////////////

  // q4.4 gain with round half up and a 16 bit clamp
  function automatic int scale_clamp(input int x, input int g, output logic clamped);
    longint y;
    y       = (longint'(x) * longint'(g) + GAIN_HALF) >>> `INTERP_GAIN_FRAC;
    clamped = (y > 32767) || (y < -32768);
    if (y > 32767) begin
      y = 32767;
    end else if (y < -32768) begin
      y = -32768;
    end
    return int'(y);
  endfunction

  // one input word becomes the sample plus PAD zeros
  // each of those beats is filtered and scaled
  function automatic void model_input(input iq_word_t word, input logic last, input int g);
    longint acc_i;
    longint acc_q;
    int     yi;
    int     yq;
    logic   ci;
    logic   cq;
    for (int beat = 0; beat <= PAD; beat++) begin
      for (int k = TAPS - 1; k > 0; k--) begin
        hist_i[k] = hist_i[k-1];
        hist_q[k] = hist_q[k-1];
      end
      hist_i[0] = (beat == 0) ? int'($signed(word[31:16])) : 0;
      hist_q[0] = (beat == 0) ? int'($signed(word[15:0])) : 0;
      acc_i = 0;
      acc_q = 0;
      for (int k = 0; k < TAPS; k++) begin
        acc_i = acc_i + longint'(hist_i[k]) * longint'(COEF[k]);
        acc_q = acc_q + longint'(hist_q[k]) * longint'(COEF[k]);
      end
      // round half up to sample scale before the gain
      yi = scale_clamp(int'((acc_i + COEF_HALF) >>> `INTERP_COEF_FRAC), g, ci);
      yq = scale_clamp(int'((acc_q + COEF_HALF) >>> `INTERP_COEF_FRAC), g, cq);
      exp_data.push_back({yi[15:0], yq[15:0]});
      // frame end rides on the last zero of the tagged sample
      exp_last.push_back(last && (beat == PAD));
      exp_sat.push_back(ci | cq);
    end
  endfunction

  //////////////////////////////////////////
  // scoreboard
  //////////////////////////////////////////

  // beat transfers on the coming rising edge
  always @(negedge clk) begin
    if (!reset && m_axis_tvalid && m_axis_tready) begin
      if (exp_data.size() == 0) begin
        fail_run("an output beat arrived while no beat was expected");
      end else begin
        if (lat_armed && first_out < 0) begin
          first_out = cycle;
        end
        if (sat) begin
          sat_count++;
        end
        check_value(m_axis_tdata, exp_data.pop_front(), "m_axis_tdata");
        check_value(32'(m_axis_tlast), 32'(exp_last.pop_front()), "m_axis_tlast");
        check_value(32'(sat), 32'(exp_sat.pop_front()), "sat");
      end
    end
  end

  //////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #DRIVE_DLY;
    end
  endtask

  // hold the word until taken and report the cycle it went in
  task automatic send_word(input iq_word_t word, input logic last, output int taken_at);
    int   waited;
    logic taken;
    waited        = 0;
    taken         = 1'b0;
    taken_at      = -1;
    s_axis_tvalid = 1'b1;
    s_axis_tdata  = word;
    s_axis_tlast  = last;
    while (!taken && waited < TIMEOUT) begin
      @(negedge clk);
      taken    = s_axis_tready;
      taken_at = cycle;
      @(posedge clk);
      #DRIVE_DLY;
      waited++;
    end
    if (!taken) begin
      fail_run("timeout: the DUT never accepted an input word");
    end else begin
      s_axis_tvalid = 1'b0;
      s_axis_tlast  = 1'b0;
    end
  endtask

  task automatic send_sample(input iq_word_t word, input logic last, output int taken_at);
    model_input(word, last, int'(gain));
    if (gaps_en) begin
      idle_cycles($urandom_range(3));
    end
    send_word(word, last, taken_at);
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_data.size() != 0 && waited < TIMEOUT) begin
      @(posedge clk);
      #DRIVE_DLY;
      waited++;
    end
    if (exp_data.size() != 0) begin
      fail_run("timeout: expected output beats never came out");
    end
  endtask

  // full scale favours the rails
  function automatic logic [15:0] random_lane(input logic full_scale);
    logic [15:0] v;
    v = 16'($urandom);
    if (full_scale) begin
      case ($urandom_range(2))
        0:       v = 16'h7fff;
        1:       v = 16'h8000;
        default: v = v;
      endcase
    end
    return v;
  endfunction

  // gain only changes with the pipeline empty
  task automatic run_frame(input int len, input int g, input logic full_scale);
    int taken_at;
    gain = gain_t'(g);
    for (int n = 0; n < len; n++) begin
      send_sample({random_lane(full_scale), random_lane(full_scale)}, n == len - 1, taken_at);
    end
    wait_drain();
  endtask

  initial begin
    int t_first;
    int t_prev;
    int t_now;
    void'($urandom(55943));
    reset         = 1'b1;
    s_axis_tvalid = 1'b0;
    s_axis_tdata  = '0;
    s_axis_tlast  = 1'b0;
    gain          = 8'd16;
    for (int k = 0; k < TAPS; k++) begin
      hist_i[k] = 0;
      hist_q[k] = 0;
    end
    repeat (5) @(posedge clk);
    #DRIVE_DLY;
    reset = 1'b0;

    // idle state after reset
    @(negedge clk);
    check_value(32'(m_axis_tvalid), 32'd0, "m_axis_tvalid after reset");
    check_value(32'(sat), 32'd0, "sat after reset");
    check_value(32'(s_axis_tready), 32'd1, "s_axis_tready after reset");
    idle_cycles(1);

    // impulse response is the rounded triangle times the sample
    send_sample({16'sd1200, -16'sd2400}, 1'b0, t_now);
    send_sample(32'h0, 1'b0, t_now);
    send_sample(32'h0, 1'b1, t_now);
    wait_drain();

    // random frames at unity gain
    repeat (8) run_frame($urandom_range(6, 1), 16, 1'b0);

    // high gains on full scale input
    repeat (8) run_frame($urandom_range(6, 1), $urandom_range(255, 8), 1'b1);
    if (sat_count == 0) begin
      fail_run("no clamped output beat was seen at high gain");
    end

    // stalls on both sides
    bp_en   = 1'b1;
    gaps_en = 1'b1;
    repeat (10) run_frame($urandom_range(6, 1), $urandom_range(40, 4), 1'($urandom_range(1)));
    bp_en   = 1'b0;
    gaps_en = 1'b0;
    idle_cycles(2);

    // full rate gives one sample every PAD + 1 clocks
    lat_armed = 1'b1;
    gain      = 8'd16;
    send_sample({random_lane(1'b0), random_lane(1'b0)}, 1'b0, t_first);
    t_prev = t_first;
    for (int n = 1; n < 6; n++) begin
      send_sample({random_lane(1'b0), random_lane(1'b0)}, n == 5, t_now);
      check_value(32'(t_now - t_prev), 32'(PAD + 1), "input acceptance spacing");
      t_prev = t_now;
    end
    wait_drain();
    check_value(32'(first_out - t_first), 32'd3, "first output latency");

    // stray beats after the drain would hit the scoreboard
    idle_cycles(10);
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// ==== hdl/axis_fir_interp.sv ====
/*
  interpolation lowpass FIR
  8-tap filter on both i and q lanes of a zero-stuffed stream,
  round half up into 16 bits, registered output with back-pressure
*/
`include "interp_settings.svh"

module axis_fir_interp
  import interp_pkg::*;
(
  input  logic     clk,
  input  logic     reset,

  // zero-stuffed input
  input  logic     s_axis_tvalid,
  output logic     s_axis_tready,
  input  iq_word_t s_axis_tdata,
  input  logic     s_axis_tlast,

  // filtered output
  output logic     m_axis_tvalid,
  input  logic     m_axis_tready,
  output iq_word_t m_axis_tdata,
  output logic     m_axis_tlast
);

  localparam int TAPS = `INTERP_TAPS;
  localparam int SW   = `INTERP_SAMPLE_W;

  // half an output lsb in accumulator scale
  localparam acc_t ROUND_HALF = acc_t'(1) <<< (`INTERP_COEF_FRAC - 1);

  ////////////////////////////////////////
  // signals
  ////////////////////////////////////////

  // history, the incoming sample is tap 0
  sample_t i_hist [0:TAPS-2];
  sample_t q_hist [0:TAPS-2];

  // full tap windows
  sample_t i_win [0:TAPS-1];
  sample_t q_win [0:TAPS-1];

  sample_t s_i;
  sample_t s_q;

  acc_t    acc_i;
  acc_t    acc_q;
  acc_t    rnd_i;
  acc_t    rnd_q;

  logic    s_frame;

  // split the word into lanes
  assign s_i = sample_t'(s_axis_tdata[2*SW-1:SW]);
  assign s_q = sample_t'(s_axis_tdata[SW-1:0]);

  assign s_frame = s_axis_tvalid & s_axis_tready;

  // take a beat when the output slot is free or draining
  assign s_axis_tready = ~m_axis_tvalid | m_axis_tready;

  ////////////////////////////////////////
  // delay line
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int k = 0; k < TAPS - 1; k++) begin
        i_hist[k] <= '0;
        q_hist[k] <= '0;
      end
    end else if (s_frame) begin
      i_hist[0] <= s_i;
      q_hist[0] <= s_q;
      // history keeps running across frames
      for (int k = 1; k < TAPS - 1; k++) begin
        i_hist[k] <= i_hist[k-1];
        q_hist[k] <= q_hist[k-1];
      end
    end
  end

  // window seen after this beat shifts in
  always_comb begin
    i_win[0] = s_i;
    q_win[0] = s_q;
    for (int k = 1; k < TAPS; k++) begin
      i_win[k] = i_hist[k-1];
      q_win[k] = q_hist[k-1];
    end
  end

  ////////////////////////////////////////
  // dot product and rounding
  ////////////////////////////////////////
  always_comb begin
    acc_i = '0;
    acc_q = '0;
    for (int k = 0; k < TAPS; k++) begin
      acc_i = acc_i + acc_t'(i_win[k]) * acc_t'(INTERP_COEFS[k]);
      acc_q = acc_q + acc_t'(q_win[k]) * acc_t'(INTERP_COEFS[k]);
    end
    // round half up, back to sample scale
    rnd_i = (acc_i + ROUND_HALF) >>> `INTERP_COEF_FRAC;
    rnd_q = (acc_q + ROUND_HALF) >>> `INTERP_COEF_FRAC;
  end

  ////////////////////////////////////////
  // output register
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      m_axis_tvalid <= 1'b0;
    end else if (s_frame) begin
      m_axis_tvalid <= 1'b1;
    end else if (m_axis_tready) begin
      m_axis_tvalid <= 1'b0;
    end
  end

  // payload follows the accepted beat
  always_ff @(posedge clk) begin
    if (s_frame) begin
      // unity gain per phase, the 16-bit slice cannot wrap
      m_axis_tdata <= {sample_t'(rnd_i), sample_t'(rnd_q)};
      m_axis_tlast <= s_axis_tlast;
    end
  end

endmodule

// ==== hdl/axis_gain_sat.sv ====
/*
  gain and saturation stage
  scales both lanes by a q4.4 gain, rounds half up, clamps to 16 bits
  and flags beats where either lane was clamped
*/
`include "interp_settings.svh"

module axis_gain_sat
  import interp_pkg::*;
(
  input  logic     clk,
  input  logic     reset,

  // filtered input
  input  logic     s_axis_tvalid,
  output logic     s_axis_tready,
  input  iq_word_t s_axis_tdata,
  input  logic     s_axis_tlast,

  // level control, taken at each accepted beat
  input  gain_t    gain,

  // scaled output
  output logic     m_axis_tvalid,
  input  logic     m_axis_tready,
  output iq_word_t m_axis_tdata,
  output logic     m_axis_tlast,
  output logic     sat
);

  localparam int SW     = `INTERP_SAMPLE_W;
  // signed sample times zero-extended gain
  localparam int PROD_W = `INTERP_SAMPLE_W + `INTERP_GAIN_W + 1;

  typedef logic signed [PROD_W-1:0] prod_t;

  localparam prod_t ROUND_HALF = prod_t'(1) <<< (`INTERP_GAIN_FRAC - 1);
  localparam prod_t SAT_MAX    = prod_t'(2 ** (SW - 1) - 1);
  localparam prod_t SAT_MIN    = -prod_t'(2 ** (SW - 1));

  logic [SW:0] lane_i;
  logic [SW:0] lane_q;
  logic        s_frame;

  // returns {clamped, result}
  function automatic logic [SW:0] scale_lane(input sample_t x, input gain_t g);
    prod_t   prod;
    prod_t   rnd;
    sample_t y;
    logic    clamped;
    prod    = x * $signed({1'b0, g});
    rnd     = (prod + ROUND_HALF) >>> `INTERP_GAIN_FRAC;
    clamped = 1'b1;
    if (rnd > SAT_MAX) begin
      y = sample_t'(SAT_MAX);
    end else if (rnd < SAT_MIN) begin
      y = sample_t'(SAT_MIN);
    end else begin
      y       = sample_t'(rnd);
      clamped = 1'b0;
    end
    return {clamped, y};
  endfunction

  assign lane_i = scale_lane(sample_t'(s_axis_tdata[2*SW-1:SW]), gain);
  assign lane_q = scale_lane(sample_t'(s_axis_tdata[SW-1:0]), gain);

  assign s_frame       = s_axis_tvalid & s_axis_tready;
  assign s_axis_tready = ~m_axis_tvalid | m_axis_tready;

  ////////////////////////////////////////
  // output register
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      m_axis_tvalid <= 1'b0;
      sat           <= 1'b0;
    end else if (s_frame) begin
      m_axis_tvalid <= 1'b1;
      // travels with its beat
      sat           <= lane_i[SW] | lane_q[SW];
    end else if (m_axis_tready) begin
      m_axis_tvalid <= 1'b0;
      sat           <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (s_frame) begin
      m_axis_tdata <= {lane_i[SW-1:0], lane_q[SW-1:0]};
      m_axis_tlast <= s_axis_tlast;
    end
  end

endmodule

// ==== hdl/axis_interp_top.sv ====
/*
  complex x4 interpolator top level
  zero pad, lowpass FIR and gain stage chained as valid/ready streams
*/
`include "interp_settings.svh"

module axis_interp_top
  import interp_pkg::*;
(
  input  logic     clk,
  input  logic     reset,

  // baseband input
  input  logic     s_axis_tvalid,
  output logic     s_axis_tready,
  input  iq_word_t s_axis_tdata,
  input  logic     s_axis_tlast,

  input  gain_t    gain,

  // interpolated output
  output logic     m_axis_tvalid,
  input  logic     m_axis_tready,
  output iq_word_t m_axis_tdata,
  output logic     m_axis_tlast,
  output logic     sat
);

  // zero pad to FIR
  logic     pad_tvalid;
  logic     pad_tready;
  iq_word_t pad_tdata;
  logic     pad_tlast;

  // FIR to gain
  logic     fir_tvalid;
  logic     fir_tready;
  iq_word_t fir_tdata;
  logic     fir_tlast;

  ////////////////////////////////////////
  // rate x4 by zero stuffing
  ////////////////////////////////////////
  axis_zero_pad #(
    .PAD_SIZE (`INTERP_PAD_SIZE)
  ) u_zero_pad (
    .clk           (clk),
    .reset         (reset),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tlast  (s_axis_tlast),
    .m_axis_tvalid (pad_tvalid),
    .m_axis_tready (pad_tready),
    .m_axis_tdata  (pad_tdata),
    .m_axis_tlast  (pad_tlast)
  );

  // fills the zeros in
  axis_fir_interp u_fir (
    .clk           (clk),
    .reset         (reset),
    .s_axis_tvalid (pad_tvalid),
    .s_axis_tready (pad_tready),
    .s_axis_tdata  (pad_tdata),
    .s_axis_tlast  (pad_tlast),
    .m_axis_tvalid (fir_tvalid),
    .m_axis_tready (fir_tready),
    .m_axis_tdata  (fir_tdata),
    .m_axis_tlast  (fir_tlast)
  );

  axis_gain_sat u_gain (
    .clk           (clk),
    .reset         (reset),
    .s_axis_tvalid (fir_tvalid),
    .s_axis_tready (fir_tready),
    .s_axis_tdata  (fir_tdata),
    .s_axis_tlast  (fir_tlast),
    .gain          (gain),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tlast  (m_axis_tlast),
    .sat           (sat)
  );

endmodule

// ==== hdl/axis_zero_pad.sv ====
/*
  zero-stuffing upsampler
  passes each accepted sample then PAD_SIZE zero words,
  tlast marks the final pad beat of a frame
*/
module axis_zero_pad
  import interp_pkg::*;
#(
  parameter int PAD_SIZE = 3
) (
  input  logic     clk,
  input  logic     reset,

  // input stream
  input  logic     s_axis_tvalid,
  output logic     s_axis_tready,
  input  iq_word_t s_axis_tdata,
  input  logic     s_axis_tlast,

  // output stream
  output logic     m_axis_tvalid,
  input  logic     m_axis_tready,
  output iq_word_t m_axis_tdata,
  output logic     m_axis_tlast
);

  // counter must also hold the spent value PAD_SIZE + 1
  localparam int CNT_W = $clog2(PAD_SIZE + 2);
  localparam logic [CNT_W-1:0] LAST_PAD = CNT_W'(PAD_SIZE);
  localparam logic [CNT_W-1:0] SPENT    = CNT_W'(PAD_SIZE + 1);

  logic [CNT_W-1:0] pad_cnt;
  logic             burst_done;
  logic             s_frame;
  logic             m_frame;
  logic             final_beat;
  iq_word_t         data_q;

  ////////////////////////////////////////
  // handshakes
  ////////////////////////////////////////
  assign s_frame    = s_axis_tvalid & s_axis_tready;
  assign m_frame    = m_axis_tvalid & m_axis_tready;
  // last pad beat leaving this cycle
  assign final_beat = m_frame & (pad_cnt == LAST_PAD);

  // idle, or the last pad beat goes out now
  assign s_axis_tready = (pad_cnt == SPENT) |
                         ((pad_cnt == LAST_PAD) & m_axis_tready);

  ////////////////////////////////////////
  // pad counter
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      // start idle, nothing to send
      pad_cnt <= SPENT;
    end else if (s_frame) begin
      pad_cnt <= '0;
    end else if (m_frame) begin
      pad_cnt <= pad_cnt + 1'b1;
    end
  end

  // sample first, then zeros
  always_ff @(posedge clk) begin
    if (s_frame) begin
      data_q <= s_axis_tdata;
    end else if (m_frame) begin
      data_q <= '0;
    end
  end

  ////////////////////////////////////////
  // frame end tracking
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      burst_done <= 1'b0;
    end else if (s_frame) begin
      // new sample decides whether its pads close the frame
      burst_done <= s_axis_tlast;
    end else if (final_beat) begin
      burst_done <= 1'b0;
    end
  end

  assign m_axis_tvalid = (pad_cnt <= LAST_PAD);
  assign m_axis_tdata  = data_q;
  assign m_axis_tlast  = burst_done & (pad_cnt == LAST_PAD);

endmodule

// ==== hdl/interp_pkg.sv ====
/*
  complex x4 interpolator types
  lane, stream word, gain and accumulator types plus the fixed coefficient table
*/
`include "interp_settings.svh"

package interp_pkg;

  // one signed lane value
  typedef logic signed [`INTERP_SAMPLE_W-1:0]   sample_t;
  // stream word, i in upper half, q in lower half
  typedef logic        [2*`INTERP_SAMPLE_W-1:0] iq_word_t;
  // unsigned q4.4
  typedef logic        [`INTERP_GAIN_W-1:0]     gain_t;
  typedef logic signed [`INTERP_COEF_W-1:0]     coef_t;
  typedef logic signed [`INTERP_ACC_W-1:0]      acc_t;

  //////////////////////////////////////////
  // triangle taps, linear interpolation
  // each polyphase branch sums to 16384 (unity)
  //////////////////////////////////////////
  localparam coef_t INTERP_COEFS [0:`INTERP_TAPS-1] = '{
    16'sd0,
    16'sd4096,
    16'sd8192,
    16'sd12288,
    16'sd16384,
    16'sd12288,
    16'sd8192,
    16'sd4096
  };

endpackage

// ==== hdl/interp_settings.svh ====
/*
  complex x4 interpolator settings
  pad size, filter length, fixed point fractions and data widths
*/
`ifndef INTERP_SETTINGS_SVH
`define INTERP_SETTINGS_SVH

// zeros stuffed after each input sample, upsample factor is this plus one
`define INTERP_PAD_SIZE   3

// lowpass filter
`define INTERP_TAPS       8
`define INTERP_COEF_FRAC  14
`define INTERP_COEF_W     16
`define INTERP_ACC_W      36

// gain is unsigned q4.4
`define INTERP_GAIN_FRAC  4
`define INTERP_GAIN_W     8

`define INTERP_SAMPLE_W   16

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile the interpolator testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal \
  -f axis_interp_top.f \
  --top-module tb_axis_interp_top \
  -o tb_axis_interp_top \
  && ./obj_dir/tb_axis_interp_top > sim.log 2>&1 \
  || echo "compile or simulation step failed"

cat sim.log 2>/dev/null

grep -qx "Simulation finished: PASS" sim.log \
  && echo "result: pass" \
  || { echo "result: fail"; exit 1; }
